/* mem_sys_pkg.sv */
// memory subsystem shared types
// widths, command and size codes, request and fill structs
package mem_sys_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int BLOCK_BYTES = 8;           // bytes per memory line
    localparam int LINE_OFS_W  = 3;           // byte offset bits inside a line

    typedef logic [31:0] addr_t;              // byte address
    typedef logic [63:0] mem_block_t;         // one line, also the data bus
    typedef logic [3:0]  mem_tag_t;           // 0 = no tag
    typedef logic [1:0]  mem_cmd_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [15:0] lat_count_t;         // latency countdown

    ////////////////////
    // command codes
    ////////////////////
    localparam mem_cmd_t BUS_NONE  = 2'h0;
    localparam mem_cmd_t BUS_LOAD  = 2'h1;
    localparam mem_cmd_t BUS_STORE = 2'h2;

    // access sizes
    localparam mem_size_t SIZE_BYTE   = 2'h0;
    localparam mem_size_t SIZE_HALF   = 2'h1;
    localparam mem_size_t SIZE_WORD   = 2'h2;
    localparam mem_size_t SIZE_DOUBLE = 2'h3;

    ////////////////////
    // structs
    ////////////////////
    // access request, allocator to block store
    typedef struct packed {
        logic       valid;    // accepted command this cycle
        logic       store;    // 1 = store, 0 = load
        addr_t      addr;
        mem_size_t  size;
        mem_block_t data;     // store data, low lanes used for partial sizes
    } mem_req_t;

    // tag start, allocator to tag table
    typedef struct packed {
        logic     valid;
        logic     load;       // loads must wait for the return bus
        mem_tag_t tag;
    } tag_fill_t;

endpackage

/* mem_tag_alloc.sv */
// tag allocator for the memory subsystem
// admits commands, picks the lowest free tag, drives request and table fill
`timescale 1ns/1ps

module mem_tag_alloc #(
    parameter int NUM_TAGS  = 15,
    parameter int MEM_LINES = 256
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  mem_sys_pkg::mem_cmd_t   cmd,
    input  mem_sys_pkg::addr_t      addr,
    input  mem_sys_pkg::mem_block_t wdata,
    input  mem_sys_pkg::mem_size_t  size,
    input  logic [NUM_TAGS:1]       free_mask,   // bit i set = tag i idle
    output mem_sys_pkg::mem_req_t   req,
    output mem_sys_pkg::tag_fill_t  fill,
    output mem_sys_pkg::mem_tag_t   response
);

    // first byte past the array
    localparam mem_sys_pkg::addr_t MEM_BYTES = MEM_LINES * mem_sys_pkg::BLOCK_BYTES;

    logic                  cmd_valid;   // load or store
    logic                  in_range;
    logic                  any_free;
    logic                  accept;
    mem_sys_pkg::mem_tag_t free_tag;    // lowest free tag, 0 if none

    ////////////////////
    // decode and check
    ////////////////////
    assign cmd_valid = (cmd == mem_sys_pkg::BUS_LOAD) || (cmd == mem_sys_pkg::BUS_STORE);
    assign in_range  = (addr < MEM_BYTES);
    assign any_free  = |free_mask;
    assign accept    = cmd_valid && in_range && any_free;

    // priority pick, walk down so the lowest free tag wins
    always_comb begin
        free_tag = '0;
        for (int i = NUM_TAGS; i >= 1; i--) begin
            if (free_mask[i]) free_tag = mem_sys_pkg::mem_tag_t'(i);
        end
    end

    ////////////////////
    // outputs to store and table
    ////////////////////
    always_comb begin
        req.valid = accept;
        req.store = (cmd == mem_sys_pkg::BUS_STORE);
        req.addr  = addr;
        req.size  = size;
        req.data  = wdata;
    end

    always_comb begin
        fill.valid = accept;
        fill.load  = (cmd == mem_sys_pkg::BUS_LOAD);   // stores only hold the tag
        fill.tag   = free_tag;
    end

    // response shows the tag for one cycle after the accepting edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            response <= '0;
        end else begin
            response <= accept ? free_tag : '0;   // refusals report 0
        end
    end

endmodule

/* mem_block_store.sv */
// line memory for the subsystem
// combinational sized lane read, sized merge write at the clock edge
`timescale 1ns/1ps

module mem_block_store #(
    parameter int MEM_LINES = 256
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  mem_sys_pkg::mem_req_t   req,
    output mem_sys_pkg::mem_block_t load_data   // zero-extended lane
);

    localparam int LINE_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    mem_sys_pkg::mem_block_t mem_array [MEM_LINES];

    logic [LINE_W-1:0]                  line_idx;
    logic [mem_sys_pkg::LINE_OFS_W-1:0] byte_ofs;
    mem_sys_pkg::mem_block_t            cur_line;
    mem_sys_pkg::mem_block_t            merged_line;

    assign line_idx = req.addr[mem_sys_pkg::LINE_OFS_W +: LINE_W];
    assign byte_ofs = req.addr[mem_sys_pkg::LINE_OFS_W-1:0];
    assign cur_line = mem_array[line_idx];       // addressed line, read every cycle

    ////////////////////
    // load lane select
    ////////////////////
    // offset bits below the access size are ignored
    always_comb begin
        load_data = '0;
        case (req.size)
            mem_sys_pkg::SIZE_BYTE: load_data[7:0]  = cur_line[{byte_ofs, 3'b000} +: 8];
            mem_sys_pkg::SIZE_HALF: load_data[15:0] = cur_line[{byte_ofs[2:1], 4'b0000} +: 16];
            mem_sys_pkg::SIZE_WORD: load_data[31:0] = cur_line[{byte_ofs[2], 5'b00000} +: 32];
            default:                load_data       = cur_line;   // double
        endcase
    end

    ////////////////////
    // store merge
    ////////////////////
    always_comb begin
        merged_line = cur_line;                  // untouched lanes keep old bytes
        case (req.size)
            mem_sys_pkg::SIZE_BYTE: merged_line[{byte_ofs, 3'b000} +: 8] = req.data[7:0];
            mem_sys_pkg::SIZE_HALF:
                merged_line[{byte_ofs[2:1], 4'b0000} +: 16] = req.data[15:0];
            mem_sys_pkg::SIZE_WORD:
                merged_line[{byte_ofs[2], 5'b00000} +: 32] = req.data[31:0];
            default: merged_line = req.data;
        endcase
    end

    // write lands at the accepting edge, so the next load sees it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MEM_LINES; i++) begin
                mem_array[i] <= '0;
            end
        end else if (req.valid && req.store) begin
            mem_array[line_idx] <= merged_line;
        end
    end

endmodule

/* mem_tag_table.sv */
// in-flight tag table
// per tag countdown, waiting-for-bus flag and the held load block
`timescale 1ns/1ps

module mem_tag_table #(
    parameter int NUM_TAGS = 15,
    parameter int LATENCY  = 8
) (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  mem_sys_pkg::tag_fill_t                 fill,
    input  mem_sys_pkg::mem_block_t                load_data,
    input  mem_sys_pkg::mem_tag_t                  grant,       // 0 = nothing granted
    output logic [NUM_TAGS:1]                      free_mask,
    output logic [NUM_TAGS:1]                      ready_mask,
    output mem_sys_pkg::mem_block_t [NUM_TAGS:1]   held_data
);

    localparam mem_sys_pkg::lat_count_t START_COUNT = mem_sys_pkg::lat_count_t'(LATENCY);

    mem_sys_pkg::lat_count_t count [NUM_TAGS:1];   // cycles until done
    logic [NUM_TAGS:1]       waiting;              // load not yet on the bus
    logic [NUM_TAGS:1]       fill_hit;             // fill targets tag i
    logic [NUM_TAGS:1]       grant_hit;            // arbiter took tag i

    ////////////////////
    // tag decode
    ////////////////////
    always_comb begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            fill_hit[i]  = fill.valid && (fill.tag == mem_sys_pkg::mem_tag_t'(i));
            grant_hit[i] = (grant == mem_sys_pkg::mem_tag_t'(i));
        end
    end

    // status masks straight from the state
    always_comb begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            free_mask[i]  = (count[i] == '0) && !waiting[i];
            ready_mask[i] = (count[i] == '0) && waiting[i];
        end
    end

    ////////////////////
    // countdown and flags
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                count[i] <= '0;
            end
            waiting <= '0;
        end else begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                if (fill_hit[i]) begin
                    count[i]   <= START_COUNT;         // LATENCY from the accepting edge
                    waiting[i] <= fill.load;
                end else begin
                    if (count[i] != '0) count[i] <= count[i] - 1'b1;
                    if (grant_hit[i])   waiting[i] <= 1'b0;   // returned this edge
                end
            end
        end
    end

    // load data captured with the fill, read out by the arbiter later
    always_ff @(posedge clock) begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if (fill_hit[i] && fill.load) held_data[i] <= load_data;
        end
    end

endmodule

/* mem_return_arb.sv */
// return bus arbiter
// grants the lowest ready tag, registers its tag and block onto the bus
`timescale 1ns/1ps

module mem_return_arb #(
    parameter int NUM_TAGS = 15
) (
    input  logic                                 clock,
    input  logic                                 arst_n,
    input  logic [NUM_TAGS:1]                    ready_mask,
    input  mem_sys_pkg::mem_block_t [NUM_TAGS:1] held_data,
    output mem_sys_pkg::mem_tag_t                grant,   // 0 = bus idle
    output mem_sys_pkg::mem_tag_t                rtag,
    output mem_sys_pkg::mem_block_t              rdata
);

    mem_sys_pkg::mem_block_t sel_data;   // block of the granted tag

    // walk down, last hit is the lowest ready tag
    always_comb begin
        grant    = '0;
        sel_data = '0;
        for (int i = NUM_TAGS; i >= 1; i--) begin
            if (ready_mask[i]) begin
                grant    = mem_sys_pkg::mem_tag_t'(i);
                sel_data = held_data[i];
            end
        end
    end

    ////////////////////
    // return register
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rtag  <= '0;
            rdata <= '0;
        end else begin
            rtag  <= grant;      // 0 when nothing ready
            rdata <= sel_data;   // zero with no grant
        end
    end

endmodule

/* mem_sys.sv */
// tagged pipelined main memory, top level
// allocator, block store, tag table and return arbiter
`timescale 1ns/1ps

module mem_sys #(
    parameter int LATENCY   = 8,
    parameter int NUM_TAGS  = 15,
    parameter int MEM_LINES = 256
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  mem_sys_pkg::mem_cmd_t   cmd,
    input  mem_sys_pkg::addr_t      addr,
    input  mem_sys_pkg::mem_block_t wdata,
    input  mem_sys_pkg::mem_size_t  size,
    output mem_sys_pkg::mem_tag_t   response,   // tag of accepted command, 0 = refused
    output mem_sys_pkg::mem_block_t rdata,
    output mem_sys_pkg::mem_tag_t   rtag        // tag of returning load, 0 = none
);

    ////////////////////
    // internal nets
    ////////////////////
    mem_sys_pkg::mem_req_t                req;
    mem_sys_pkg::tag_fill_t               fill;
    mem_sys_pkg::mem_block_t              load_data;
    logic [NUM_TAGS:1]                    free_mask;
    logic [NUM_TAGS:1]                    ready_mask;
    mem_sys_pkg::mem_block_t [NUM_TAGS:1] held_data;
    mem_sys_pkg::mem_tag_t                grant;

    mem_tag_alloc #(.NUM_TAGS(NUM_TAGS), .MEM_LINES(MEM_LINES)) i_alloc (
        .clock, .arst_n, .cmd, .addr, .wdata, .size,
        .free_mask, .req, .fill, .response
    );

    mem_block_store #(.MEM_LINES(MEM_LINES)) i_store (
        .clock, .arst_n, .req, .load_data
    );

    mem_tag_table #(.NUM_TAGS(NUM_TAGS), .LATENCY(LATENCY)) i_table (
        .clock, .arst_n, .fill, .load_data, .grant,
        .free_mask, .ready_mask, .held_data
    );

    mem_return_arb #(.NUM_TAGS(NUM_TAGS)) i_arb (
        .clock, .arst_n, .ready_mask, .held_data, .grant, .rtag, .rdata
    );

endmodule

/* mem_sys_tb.sv */
// testbench for the tagged pipelined memory subsystem
// reference memory, tag occupancy model and return scoreboard
`timescale 1ns/1ps

module mem_sys_tb;

    localparam int LATENCY   = 8;
    localparam int NUM_TAGS  = 15;
    localparam int MEM_LINES = 256;
    localparam int MEM_BYTES = MEM_LINES * 8;   // first out-of-range byte

    logic                    clock;
    logic                    arst_n;
    mem_sys_pkg::mem_cmd_t   cmd;
    mem_sys_pkg::addr_t      addr;
    mem_sys_pkg::mem_block_t wdata;
    mem_sys_pkg::mem_size_t  size;
    mem_sys_pkg::mem_tag_t   response;
    mem_sys_pkg::mem_block_t rdata;
    mem_sys_pkg::mem_tag_t   rtag;

    mem_sys_pkg::mem_block_t ref_mem [MEM_LINES];   // reference memory
    mem_sys_pkg::mem_block_t sb_data [16];           // expected block per tag
    logic                    sb_valid [16];          // load outstanding on tag
    int                      sb_edge [16];           // accepting edge of the load
    int                      free_at [16];           // first edge the tag is free again
    mem_sys_pkg::lat_count_t last_lat;               // edges taken by the last return
    int                      cycle_cnt = 0;          // rising edges so far
    int unsigned             lcg_state = 54;
    string                   test_name = "reset";
    int                      tag_errs = 0;
    int                      data_errs = 0;
    int                      lat_errs = 0;
    int                      other_errs = 0;

    mem_sys #(.LATENCY(LATENCY), .NUM_TAGS(NUM_TAGS), .MEM_LINES(MEM_LINES)) i_dut (
        .clock, .arst_n, .cmd, .addr, .wdata, .size, .response, .rdata, .rtag
    );

    always #50 clock = ~clock;                       // 100 ns period
    always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

    ////////////////////
    // helpers
    ////////////////////
    // two LCG steps keeping only the upper halves since the low bits cycle fast
    function logic [31:0] lcg_next();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic mem_sys_pkg::mem_block_t lane_mask(input mem_sys_pkg::mem_size_t s);
        case (s)
            mem_sys_pkg::SIZE_BYTE: return 64'hff;
            mem_sys_pkg::SIZE_HALF: return 64'hffff;
            mem_sys_pkg::SIZE_WORD: return 64'hffff_ffff;
            default:                return '1;
        endcase
    endfunction

    // bit shift of the lane with the offset rounded down to the access size
    function automatic int lane_shift(input mem_sys_pkg::addr_t a,
                                      input mem_sys_pkg::mem_size_t s);
        int nb;
        nb = 1 << s;
        return (int'(a[2:0]) / nb) * nb * 8;
    endfunction

    // expected zero-extended load result
    function automatic mem_sys_pkg::mem_block_t ref_load(input mem_sys_pkg::addr_t a,
                                                         input mem_sys_pkg::mem_size_t s);
        return (ref_mem[int'(a >> 3) % MEM_LINES] >> lane_shift(a, s)) & lane_mask(s);
    endfunction

    function automatic void ref_store(input mem_sys_pkg::addr_t a,
                                      input mem_sys_pkg::mem_size_t s,
                                      input mem_sys_pkg::mem_block_t d);
        mem_sys_pkg::mem_block_t m;
        int                      idx;
        m   = lane_mask(s) << lane_shift(a, s);
        idx = int'(a >> 3) % MEM_LINES;
        ref_mem[idx] = (ref_mem[idx] & ~m) | ((d << lane_shift(a, s)) & m);
    endfunction

    // lowest tag idle at the current edge or 0 for a refusal
    function automatic mem_sys_pkg::mem_tag_t predict_tag(input mem_sys_pkg::mem_cmd_t c,
                                                          input mem_sys_pkg::addr_t a);
        mem_sys_pkg::mem_tag_t t;
        t = '0;
        if ((c == mem_sys_pkg::BUS_LOAD || c == mem_sys_pkg::BUS_STORE) && a < MEM_BYTES) begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                if (t == '0 && !sb_valid[i] && cycle_cnt >= free_at[i]) begin
                    t = mem_sys_pkg::mem_tag_t'(i);
                end
            end
        end
        return t;
    endfunction

    function automatic bit all_idle();
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if (sb_valid[i] || cycle_cnt < free_at[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_tag(input string name, input mem_sys_pkg::mem_tag_t exp,
                             input mem_sys_pkg::mem_tag_t act);
        if (act !== exp) begin
            $display("ERR %s: expected tag %0d actual %0d", name, exp, act);
            tag_errs++;
        end
    endtask

    task automatic check_block(input string name, input mem_sys_pkg::mem_block_t exp,
                               input mem_sys_pkg::mem_block_t act);
        if (act !== exp) begin
            $display("ERR %s: expected data %h actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_latency(input string name, input mem_sys_pkg::lat_count_t exp,
                                 input mem_sys_pkg::lat_count_t act);
        if (act !== exp) begin
            $display("ERR %s: expected latency %0d actual %0d", name, exp, act);
            lat_errs++;
        end
    endtask

    ////////////////////
    // command and waits
    ////////////////////
    // called 5 ns after an edge and returns 5 ns after the accepting edge
    task automatic send(input mem_sys_pkg::mem_cmd_t c, input mem_sys_pkg::addr_t a,
                        input mem_sys_pkg::mem_size_t s, input mem_sys_pkg::mem_block_t d,
                        output mem_sys_pkg::mem_tag_t t);
        cmd   = c;
        addr  = a;
        size  = s;
        wdata = d;
        @(posedge clock);
        #5;
        t = response;
        check_tag(test_name, predict_tag(c, a), t);
        if (t != '0) begin
            free_at[t] = cycle_cnt + LATENCY + 1;   // stores free one edge after count hits 0
            if (c == mem_sys_pkg::BUS_LOAD) begin
                sb_data[t]  = ref_load(a, s);
                sb_edge[t]  = cycle_cnt;
                sb_valid[t] = 1'b1;
            end else begin
                ref_store(a, s, d);
            end
        end
        cmd = mem_sys_pkg::BUS_NONE;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!all_idle()) begin
            if (n >= limit) begin
                $display("%s: tags still in flight after %0d cycles", test_name, limit);
                other_errs++;
                break;
            end
            @(posedge clock);
            #5;
            n++;
        end
    endtask

    task automatic wait_return(input mem_sys_pkg::mem_tag_t t, input int limit);
        int n;
        n = 0;
        while (sb_valid[t]) begin
            if (n >= limit) begin
                $display("%s: tag %0d never returned", test_name, t);
                other_errs++;
                break;
            end
            @(posedge clock);
            #5;
            n++;
        end
    endtask

    ////////////////////
    // return checker
    ////////////////////
    // samples at the falling edge half a cycle after rtag settles
    always @(negedge clock) begin
        if (arst_n) begin
            if (rtag != '0) begin
                if (!sb_valid[rtag]) begin
                    $display("%s: tag %0d returned with no load outstanding", test_name, rtag);
                    other_errs++;
                end else begin
                    check_block(test_name, sb_data[rtag], rdata);
                    last_lat = mem_sys_pkg::lat_count_t'(cycle_cnt - sb_edge[rtag]);
                    if (last_lat < LATENCY + 1) begin
                        $display("%s: tag %0d returned after only %0d edges", test_name, rtag,
                                 last_lat);
                        other_errs++;
                    end
                    sb_valid[rtag] = 1'b0;
                end
            end else begin
                check_block({test_name, " idle bus"}, '0, rdata);   // idle bus carries zero
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        mem_sys_pkg::mem_tag_t   t;
        mem_sys_pkg::addr_t      a;
        mem_sys_pkg::addr_t      base;
        mem_sys_pkg::mem_cmd_t   c;
        logic [31:0]             r;
        int                      total;
        clock  = 1'b0;
        arst_n = 1'b0;
        cmd    = mem_sys_pkg::BUS_NONE;
        addr   = '0;
        wdata  = '0;
        size   = mem_sys_pkg::SIZE_BYTE;
        for (int i = 0; i < MEM_LINES; i++) ref_mem[i] = '0;
        for (int i = 0; i < 16; i++) begin
            sb_valid[i] = 1'b0;
            free_at[i]  = 0;
        end
        repeat (4) @(posedge clock);
        #5;
        arst_n = 1'b1;

        // quiet bus and zeroed array after reset
        for (int i = 0; i < 4; i++) send(mem_sys_pkg::BUS_NONE, '0, '0, '0, t);
        for (int i = 0; i < 6; i++) begin
            send(mem_sys_pkg::BUS_LOAD, lcg_next() % MEM_BYTES, mem_sys_pkg::SIZE_DOUBLE, '0, t);
        end
        wait_idle(100);

        // sized stores at each offset then reloads at every size
        test_name = "sized access";
        for (int s = 0; s < 4; s++) begin
            base = mem_sys_pkg::addr_t'((16 + s) * 8);
            send(mem_sys_pkg::BUS_STORE, base, mem_sys_pkg::SIZE_DOUBLE,
                 {lcg_next(), lcg_next()}, t);
            for (int o = 0; o < 8; o += (1 << s)) begin
                send(mem_sys_pkg::BUS_STORE, base + o, mem_sys_pkg::mem_size_t'(s),
                     {lcg_next(), lcg_next()}, t);
                for (int ls = 0; ls < 4; ls++) begin
                    for (int lo = 0; lo < 8; lo += (1 << ls)) begin
                        a = base + lo + (lcg_next() % (1 << ls));   // low bits ignored
                        send(mem_sys_pkg::BUS_LOAD, a, mem_sys_pkg::mem_size_t'(ls), '0, t);
                    end
                end
            end
        end
        wait_idle(100);

        // refusals leave memory alone and never return
        test_name = "refusal";
        send(mem_sys_pkg::BUS_STORE, MEM_BYTES + 40, mem_sys_pkg::SIZE_DOUBLE, '1, t);
        send(mem_sys_pkg::BUS_STORE, 32'hffff_fff0, mem_sys_pkg::SIZE_WORD, '1, t);
        send(mem_sys_pkg::BUS_NONE, 48, mem_sys_pkg::SIZE_DOUBLE, '1, t);
        send(mem_sys_pkg::BUS_LOAD, MEM_BYTES, mem_sys_pkg::SIZE_DOUBLE, '0, t);
        send(mem_sys_pkg::BUS_LOAD, 40, mem_sys_pkg::SIZE_DOUBLE, '0, t);
        send(mem_sys_pkg::BUS_LOAD, 48, mem_sys_pkg::SIZE_DOUBLE, '0, t);
        send(mem_sys_pkg::BUS_LOAD, 32'h7f0, mem_sys_pkg::SIZE_WORD, '0, t);   // high alias line
        wait_idle(100);

        // back-to-back on an idle pool gives tags in order until freed ones recycle
        test_name = "tag allocation";
        for (int i = 0; i < NUM_TAGS + 6; i++) begin
            c = (i % 3 == 2) ? mem_sys_pkg::BUS_STORE : mem_sys_pkg::BUS_LOAD;
            send(c, lcg_next() % MEM_BYTES, mem_sys_pkg::SIZE_DOUBLE,
                 {lcg_next(), lcg_next()}, t);
        end
        wait_idle(100);

        // random mix over a few lines so loads hit recent stores
        test_name = "pipelined";
        for (int i = 0; i < 400; i++) begin
            r = lcg_next();
            case (r % 8)
                0:       c = mem_sys_pkg::BUS_NONE;
                1, 2, 3: c = mem_sys_pkg::BUS_STORE;
                default: c = mem_sys_pkg::BUS_LOAD;
            endcase
            a = (r[15:12] == 4'h0) ? MEM_BYTES + lcg_next() % 4096 : lcg_next() % 256;
            send(c, a, mem_sys_pkg::mem_size_t'(r[5:4]), {lcg_next(), lcg_next()}, t);
        end
        wait_idle(200);

        // lone load on an idle system
        test_name = "single latency";
        send(mem_sys_pkg::BUS_LOAD, 16 * 8, mem_sys_pkg::SIZE_DOUBLE, '0, t);
        if (t != '0) begin
            wait_return(t, 4 * LATENCY);
            check_latency(test_name, LATENCY + 1, last_lat);
        end
        wait_idle(100);

        total = tag_errs + data_errs + lat_errs + other_errs;
        $display("errors: tag %0d, data %0d, latency %0d, other %0d",
                 tag_errs, data_errs, lat_errs, other_errs);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* mem_sys.f */
mem_sys_pkg.sv
mem_tag_alloc.sv
mem_block_store.sv
mem_tag_table.sv
mem_return_arb.sv
mem_sys.sv
mem_sys_tb.sv
